/* logic/cpc_bus_pkg.sv */
package cpc_bus_pkg;

	////////////////////////////////////////
	// CPU bus geometry
	////////////////////////////////////////

	localparam int addr_w = 16; // Z80 address bus
	localparam int data_w = 8;  // Z80 data bus

	////////////////////////////////////////
	// I/O ports, high address byte
	////////////////////////////////////////

	localparam logic [7:0] port_ga       = 8'h7F; // Gate array
	localparam logic [7:0] port_crtc_sel = 8'hBC; // CRTC register select
	localparam logic [7:0] port_crtc_val = 8'hBD; // CRTC register value
	localparam logic [7:0] port_ppi      = 8'hF7; // 8255 control
	localparam logic [7:0] port_rom_sel  = 8'hDF; // Upper ROM select

	// FEE8 pages in, FEEA pages out
	localparam logic [addr_w-3:0] port_mf2_page = 14'h3FBA;

	////////////////////////////////////////
	// Opcode fetch addresses
	////////////////////////////////////////

	localparam logic [addr_w-1:0] nmi_vector  = 16'h0066; // Z80 NMI entry
	localparam logic [addr_w-1:0] hide_vector = 16'h0065; // Hide trap

endpackage

/* logic/mf2_pkg.sv */
package mf2_pkg;

	////////////////////////////////////////
	// Multiface RAM and address windows
	////////////////////////////////////////

	localparam int ram_aw = 13; // 8 KiB

	// Top three CPU address bits while paged in
	localparam logic [2:0] win_rom = 3'b000; // 0000-1FFF
	localparam logic [2:0] win_ram = 3'b001; // 2000-3FFF

	////////////////////////////////////////
	// Shadow slots for write-only registers
	////////////////////////////////////////

	localparam logic [ram_aw-1:0] slot_pen_index = 13'h1FCF;
	localparam logic [ram_aw-1:0] slot_border    = 13'h1FDF;
	localparam logic [ram_aw-1:0] slot_pen_base  = 13'h1F90; // 16 ink entries follow
	localparam logic [ram_aw-1:0] slot_mode      = 13'h1FEF;
	localparam logic [ram_aw-1:0] slot_bank      = 13'h1FFF;
	localparam logic [ram_aw-1:0] slot_crtc_sel  = 13'h1CFF;
	localparam logic [ram_aw-1:0] slot_crtc_base = 13'h1DB0; // R0 to R15
	localparam logic [ram_aw-1:0] slot_ppi       = 13'h17FF;
	localparam logic [ram_aw-1:0] slot_rom_sel   = 13'h1AAC;

	// Front panel setting of the interface
	typedef enum logic [1:0] {
		mode_enabled  = 2'd0,
		mode_hidden   = 2'd1,
		mode_disabled = 2'd2
	} mf2_mode_t;

endpackage

/* logic/mf2_store_decode.sv */
`timescale 1ns/1ps

module mf2_store_decode (
	input  logic                             clk_sys,
	input  logic                             reset,
	input  logic [cpc_bus_pkg::addr_w-1:0]   cpu_addr,
	input  logic [cpc_bus_pkg::data_w-1:0]   cpu_dout,
	input  logic                             io_wr,
	input  logic                             mem_wr,
	input  logic                             mem_rd,
	input  logic                             mf2_en,
	output logic                             page_wr,
	output logic                             page_on,
	output logic                             rom_sel,
	output logic                             ram_sel,
	output logic                             rd_sel,
	output logic                             ram_we,
	output logic [mf2_pkg::ram_aw-1:0]       ram_addr,
	output logic [cpc_bus_pkg::data_w-1:0]   ram_din
);
	import cpc_bus_pkg::*;
	import mf2_pkg::*;

	logic              io_wr_q;
	logic              io_rise;
	logic              page_hit;
	logic [7:0]        io_port;
	logic [1:0]        ga_cmd;
	logic [4:0]        pen_index;  // Last gate array pen select
	logic [3:0]        crtc_reg;   // Last CRTC register select
	logic [ram_aw-1:0] store_addr;

	assign io_rise  = io_wr & ~io_wr_q;
	assign io_port  = cpu_addr[addr_w-1:addr_w-8];
	assign ga_cmd   = cpu_dout[7:6];
	assign page_hit = cpu_addr[addr_w-1:2] == port_mf2_page;

	// Windows seen only while paged in
	assign rom_sel = mf2_en & (cpu_addr[addr_w-1:ram_aw] == win_rom);
	assign ram_sel = mf2_en & (cpu_addr[addr_w-1:ram_aw] == win_ram);
	assign rd_sel  = mem_rd & ram_sel;

	////////////////////////////////////////
	// Register write to shadow slot
	////////////////////////////////////////

	always_comb begin
		store_addr = '0; // No slot
		case (io_port)
			port_ga: begin
				case (ga_cmd)
					2'b00: store_addr = slot_pen_index;
					2'b01: store_addr = pen_index[4] ? slot_border :
						slot_pen_base + {{(ram_aw-4){1'b0}}, pen_index[3:0]};
					2'b10: store_addr = slot_mode;
					default: store_addr = slot_bank;
				endcase
			end
			port_crtc_sel: store_addr = slot_crtc_sel;
			port_crtc_val: store_addr = slot_crtc_base + {{(ram_aw-4){1'b0}}, crtc_reg};
			port_ppi:      store_addr = slot_ppi;
			port_rom_sel:  store_addr = slot_rom_sel;
			default:       store_addr = '0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			io_wr_q <= 1'b0;
			page_wr <= 1'b0;
			ram_we  <= 1'b0;
		end else begin
			io_wr_q <= io_wr;
			page_wr <= io_rise & page_hit; // One clock strobe
			if (io_rise && page_hit)
				ram_we <= 1'b0;
			else
				ram_we <= (io_rise && store_addr != '0) || (mem_wr && ram_sel);
		end
	end

	// Port request and register copies
	always_ff @(posedge clk_sys) begin
		page_on <= ~cpu_addr[1]; // FEE8 in, FEEA out
		ram_din <= cpu_dout;
		if (io_rise && !page_hit && store_addr != '0)
			ram_addr <= store_addr;
		else
			ram_addr <= cpu_addr[ram_aw-1:0];
		if (io_rise && !page_hit) begin
			if (io_port == port_ga && ga_cmd == 2'b00)
				pen_index <= cpu_dout[4:0];
			if (io_port == port_crtc_sel)
				crtc_reg <= cpu_dout[3:0];
		end
	end

endmodule

/* logic/mf2_control.sv */
`timescale 1ns/1ps

module mf2_control (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic                           m1,
	input  logic                           key_nmi,
	input  logic                           page_wr,
	input  logic                           page_on,
	input  logic [cpc_bus_pkg::addr_w-1:0] cpu_addr,
	input  mf2_pkg::mf2_mode_t             mf2_mode,
	output logic                           nmi,
	output logic                           mf2_en
);
	import cpc_bus_pkg::*;
	import mf2_pkg::*;

	logic m1_q;
	logic key_q;
	logic m1_rise;
	logic key_rise;
	logic hidden; // Paging port ignored while set

	assign m1_rise  = m1 & ~m1_q;
	assign key_rise = key_nmi & ~key_q;

	////////////////////////////////////////
	// NMI, paging and hide trap
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			m1_q   <= 1'b0;
			key_q  <= 1'b0;
			nmi    <= 1'b0;
			mf2_en <= 1'b0;
			hidden <= mf2_mode != mode_enabled;
		end else begin
			m1_q  <= m1;
			key_q <= key_nmi;

			// Button press while not paged in
			if (key_rise && !mf2_en && mf2_mode != mode_disabled)
				nmi <= 1'b1;

			// CPU takes the NMI
			if (nmi && m1_rise && cpu_addr == nmi_vector) begin
				mf2_en <= 1'b1;
				hidden <= 1'b0;
				nmi    <= 1'b0;
			end

			if (mf2_en && m1_rise && cpu_addr == hide_vector)
				hidden <= 1'b1; // Return path of the Multiface code

			if (page_wr)
				mf2_en <= page_on & ~hidden;
		end
	end

endmodule

/* logic/mf2_ram.sv */
`timescale 1ns/1ps

module mf2_ram (
	input  logic                           clk_sys,
	input  logic                           ram_we,
	input  logic                           rd_sel,
	input  logic [mf2_pkg::ram_aw-1:0]     ram_addr,
	input  logic [cpc_bus_pkg::data_w-1:0] ram_din,
	output logic [cpc_bus_pkg::data_w-1:0] mf2_dout
);
	import cpc_bus_pkg::*;
	import mf2_pkg::*;

	logic [data_w-1:0] mem [0:(1 << ram_aw) - 1];
	logic [data_w-1:0] q;

	////////////////////////////////////////
	// Single port with write-through
	////////////////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (ram_we) begin
			mem[ram_addr] <= ram_din;
			q             <= ram_din; // New byte shows at once
		end else begin
			q <= mem[ram_addr];
		end
	end

	// Open bus reads as all ones
	assign mf2_dout = rd_sel ? q : '1;

endmodule

/* logic/mf2_top.sv */
`timescale 1ns/1ps

module mf2_top (
	input  logic                           clk_sys,
	input  logic                           reset,
	input  logic [cpc_bus_pkg::addr_w-1:0] cpu_addr,
	input  logic [cpc_bus_pkg::data_w-1:0] cpu_dout,
	input  logic                           io_wr,
	input  logic                           mem_wr,
	input  logic                           mem_rd,
	input  logic                           m1,
	input  logic                           key_nmi,
	input  mf2_pkg::mf2_mode_t             mf2_mode,
	output logic                           nmi,
	output logic                           mf2_en,
	output logic                           rom_sel,
	output logic                           ram_sel,
	output logic [cpc_bus_pkg::data_w-1:0] mf2_dout
);
	import cpc_bus_pkg::*;
	import mf2_pkg::*;

	logic              page_wr;
	logic              page_on;
	logic              rd_sel;
	logic              ram_we;
	logic [ram_aw-1:0] ram_addr;
	logic [data_w-1:0] ram_din;

	mf2_store_decode u_decode (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.mem_wr   (mem_wr),
		.mem_rd   (mem_rd),
		.mf2_en   (mf2_en),
		.page_wr  (page_wr),
		.page_on  (page_on),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel),
		.rd_sel   (rd_sel),
		.ram_we   (ram_we),
		.ram_addr (ram_addr),
		.ram_din  (ram_din)
	);

	mf2_control u_control (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.m1       (m1),
		.key_nmi  (key_nmi),
		.page_wr  (page_wr),
		.page_on  (page_on),
		.cpu_addr (cpu_addr),
		.mf2_mode (mf2_mode),
		.nmi      (nmi),
		.mf2_en   (mf2_en)
	);

	mf2_ram u_ram (
		.clk_sys  (clk_sys),
		.ram_we   (ram_we),
		.rd_sel   (rd_sel),
		.ram_addr (ram_addr),
		.ram_din  (ram_din),
		.mf2_dout (mf2_dout)
	);

endmodule

/* sim/mf2_clk_gen.sv */
`timescale 1ns/1ps

module mf2_clk_gen (
	output logic clk_sys,
	output logic reset
);

	// 50 MHz system clock
	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk_sys); // Two reset clocks
		@(negedge clk_sys);
		reset = 1'b0;
	end

endmodule

/* sim/mf2_chk.sv */
`timescale 1ns/1ps

module mf2_chk (
	input logic clk_sys,
	input logic reset,
	input logic nmi,
	input logic mf2_en
);

	int assert_fails = 0; // Failed assertion count

	////////////////////////////////////////
	// Control output rules
	////////////////////////////////////////

	// The vector fetch that pages in also drops nmi
	nmi_en_overlap: assert property (@(posedge clk_sys) disable iff (reset)
		(nmi && mf2_en) |=> !(nmi && mf2_en))
	else begin
		assert_fails++;
		$error("nmi and mf2_en high together for two cycles");
	end

	// Button ignored while paged in
	nmi_rise_unpaged: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(nmi) |-> !$past(mf2_en))
	else begin
		assert_fails++;
		$error("nmi rose while mf2_en was high");
	end

	nmi_fall_pages_in: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(nmi) |-> mf2_en)
	else begin
		assert_fails++;
		$error("nmi fell without mf2_en going high");
	end

endmodule

bind mf2_top mf2_chk u_chk (
	.clk_sys (clk_sys),
	.reset   (reset),
	.nmi     (nmi),
	.mf2_en  (mf2_en)
);

/* sim/mf2_tb.sv */
`timescale 1ns/1ps

module mf2_tb;
	import cpc_bus_pkg::*;
	import mf2_pkg::*;

	localparam int max_ops    = 51;               // Lines in the stimulus file
	localparam int max_cycles = 4 * max_ops + 50; // Four clocks per operation

	logic              clk_sys;
	logic              reset;
	logic [addr_w-1:0] cpu_addr;
	logic [data_w-1:0] cpu_dout;
	logic              io_wr;
	logic              mem_wr;
	logic              mem_rd;
	logic              m1;
	logic              key_nmi;
	mf2_mode_t         mf2_mode;
	logic              nmi;
	logic              mf2_en;
	logic              rom_sel;
	logic              ram_sel;
	logic [data_w-1:0] mf2_dout;

	logic [15:0] stim [0:4*max_ops-1]; // Four words per operation
	int          cycles;

	mf2_clk_gen u_clk (
		.clk_sys (clk_sys),
		.reset   (reset)
	);

	mf2_top UUT (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.cpu_addr (cpu_addr),
		.cpu_dout (cpu_dout),
		.io_wr    (io_wr),
		.mem_wr   (mem_wr),
		.mem_rd   (mem_rd),
		.m1       (m1),
		.key_nmi  (key_nmi),
		.mf2_mode (mf2_mode),
		.nmi      (nmi),
		.mf2_en   (mf2_en),
		.rom_sel  (rom_sel),
		.ram_sel  (ram_sel),
		.mf2_dout (mf2_dout)
	);

	////////////////////////////////////////
	// Helpers
	////////////////////////////////////////

	task automatic compare_value(input string name, input logic [7:0] actual,
			input logic [7:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t: %s is %h, expected %h", $time, name, actual,
				expected);
			$display("Regression failed");
			$fatal(1, "Stopped at first mismatch");
		end
	endtask

	task automatic release_bus();
		io_wr   = 1'b0;
		mem_wr  = 1'b0;
		mem_rd  = 1'b0;
		m1      = 1'b0;
		key_nmi = 1'b0;
	endtask

	// Called on a falling edge, returns on a falling edge four clocks later
	task automatic run_op(input logic [3:0] op, input logic [15:0] addr,
			input logic [7:0] data, input logic [7:0] expected);
		cpu_addr = addr;
		cpu_dout = data;
		case (op)
			4'd1: io_wr = 1'b1;
			4'd2: mem_wr = 1'b1;
			4'd3: mem_rd = 1'b1;
			4'd4: m1 = 1'b1;
			4'd5: key_nmi = 1'b1;
			4'd6: mf2_mode = mf2_mode_t'(data[1:0]);
			default: begin
				$display("Unknown operation code %0d in the stimulus file", op);
				$display("Regression failed");
				$fatal(1, "Bad stimulus line");
			end
		endcase
		repeat (3) @(posedge clk_sys);
		@(negedge clk_sys);
		if (op == 4'd3) begin
			compare_value("mf2_dout", mf2_dout, expected);
		end else begin
			compare_value("nmi", {7'b0, nmi}, {7'b0, expected[3]});
			compare_value("mf2_en", {7'b0, mf2_en}, {7'b0, expected[2]});
			compare_value("rom_sel", {7'b0, rom_sel}, {7'b0, expected[1]});
			compare_value("ram_sel", {7'b0, ram_sel}, {7'b0, expected[0]});
		end
		release_bus();
		@(negedge clk_sys); // Idle clock
	endtask

	// Run limit
	always @(posedge clk_sys) begin
		if (reset) begin
			cycles <= 0;
		end else begin
			cycles <= cycles + 1;
			if (cycles >= max_cycles) begin
				$display("Timeout after %0d cycles, stimulus did not finish", cycles);
				$display("Regression failed");
				$fatal(1, "Cycle limit reached");
			end
		end
	end

	////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////

	initial begin
		logic [3:0] op;
		cpu_addr   = '0;
		cpu_dout   = '0;
		mf2_mode   = mode_enabled;
		release_bus();
		for (int i = 0; i < 4 * max_ops; i++)
			stim[i] = '0; // Op 0 ends the run
		$readmemh("sim/mf2_stim.txt", stim);

		wait (reset == 1'b0);
		@(negedge clk_sys);
		for (int n = 0; n < max_ops; n++) begin
			op = stim[4*n][3:0];
			if (op == 4'd0)
				break;
			run_op(op, stim[4*n+1], stim[4*n+2][7:0], stim[4*n+3][7:0]);
		end

		if (UUT.u_chk.assert_fails == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

/* sim/mf2_stim.txt */
// op addr data expect, all hex
// op 1 io write, 2 mem write, 3 mem read (expect mf2_dout), 4 m1, 5 key, 6 mode
// expect for ops other than 3 is {nmi, mf2_en, rom_sel, ram_sel}
// After reset, not paged in
3 2100 00 FF
6 0000 00 00
// NMI button and vector fetch
5 0000 00 08
4 0066 00 06
6 2000 00 05
6 4000 00 04
// Plain RAM access in the window
2 2345 A5 05
3 2345 00 A5
2 3FF0 5A 05
3 3FF0 00 5A
3 0345 00 FF
// Unmapped port leaves RAM alone
2 2A7E 11 05
1 0A7E 99 06
3 2A7E 00 11
// Gate array writes
1 7F00 03 04
1 7F00 4B 04
1 7F00 10 04
1 7F00 54 04
1 7F00 8D 04
1 7F00 C4 04
// CRTC, 8255 and ROM select
1 BC00 07 04
1 BD00 1E 04
1 BC00 0C 04
1 BD00 30 04
1 F700 82 04
1 DF00 07 04
// Shadow slots read back
3 3FCF 00 10
3 3F93 00 4B
3 3FDF 00 54
3 3FEF 00 8D
3 3FFF 00 C4
3 3CFF 00 0C
3 3DB7 00 1E
3 3DBC 00 30
3 37FF 00 82
3 3AAC 00 07
// Paging ports
1 FEEA 00 00
3 2345 00 FF
1 FEE8 00 04
3 2345 00 A5
// Hide trap blocks paging in
4 0065 00 06
1 FEEA 00 00
1 FEE8 00 00
// Disabled mode ignores the button
6 0000 02 00
5 0000 00 00
6 0000 00 00
5 0000 00 08
4 0066 00 06
1 FEEA 00 00
1 FEE8 00 04
3 3AAC 00 07

/* all.f */
logic/cpc_bus_pkg.sv
logic/mf2_pkg.sv
logic/mf2_store_decode.sv
logic/mf2_control.sv
logic/mf2_ram.sv
logic/mf2_top.sv
sim/mf2_clk_gen.sv
sim/mf2_chk.sv
sim/mf2_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module mf2_tb -f all.f -o mf2_sim

out=$(./obj_dir/mf2_sim 2>&1 || true)
echo "$out"

if echo "$out" | grep -q "Regression passed"; then
	exit 0
fi
exit 1
